// ==== elevator.f ====
logic/elevator_pkg.sv
logic/call_register.sv
logic/dispatch.sv
logic/car_motion.sv
logic/door_control.sv
logic/elevator_top.sv
tests/clock_gen.sv
tests/elevator_tb.sv

// ==== logic/call_register.sv ====
// elevator call register
`timescale 1ns/100ps

module call_register (
	input  logic                      clk,
	input  logic                      reset,
	input  elevator_pkg::floor_mask_t btn_in,
	input  elevator_pkg::floor_mask_t btn_up_out,
	input  elevator_pkg::floor_mask_t btn_down_out,
	input  logic                      clear_valid,
	input  elevator_pkg::floor_t      clear_floor,
	input  elevator_pkg::dir_t        clear_dir,
	input  logic                      clear_all,
	output elevator_pkg::floor_mask_t cabin_calls,
	output elevator_pkg::floor_mask_t up_calls,
	output elevator_pkg::floor_mask_t down_calls
);
	import elevator_pkg::*;

	floor_mask_t clear_onehot;
	floor_mask_t clear_cabin;
	floor_mask_t clear_up;
	floor_mask_t clear_down;

	assign clear_onehot = floor_mask_t'(1) << clear_floor;
	assign clear_cabin = clear_valid ? clear_onehot : '0;

	// hall calls go only for the leaving direction, or both when nothing is left
	assign clear_up = (clear_valid && (clear_all || clear_dir == DIR_UP)) ?
		clear_onehot : '0;
	assign clear_down = (clear_valid && (clear_all || clear_dir == DIR_DOWN)) ?
		clear_onehot : '0;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			cabin_calls <= '0;
			up_calls <= '0;
			down_calls <= '0;
		end else begin
			cabin_calls <= (cabin_calls & ~clear_cabin) | btn_in; // press beats clear
			up_calls <= ((up_calls & ~clear_up) | btn_up_out) & UP_BUTTONS;
			down_calls <= ((down_calls & ~clear_down) | btn_down_out) & DOWN_BUTTONS;
		end
	end

	a_no_top_up_call: assert property (
		@(posedge clk) disable iff (!reset)
		!up_calls[TOP_FLOOR]
	) else $error("up call latched at the top floor");

endmodule

// ==== logic/car_motion.sv ====
// elevator car motion
`timescale 1ns/100ps

module car_motion (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 stop_here,
	input  logic                 calls_here,
	input  logic                 go,
	input  elevator_pkg::dir_t   go_dir,
	input  logic                 door_busy,
	output elevator_pkg::floor_t floor,
	output elevator_pkg::dir_t   dir,
	output elevator_pkg::engine_t engine,
	output elevator_pkg::floor_t level_display,
	output logic                 door_request,
	output logic                 clear_valid,
	output elevator_pkg::floor_t clear_floor,
	output elevator_pkg::dir_t   clear_dir,
	output logic                 clear_all
);
	import elevator_pkg::*;

	car_state_t          state;
	logic [TRAVEL_W-1:0] timer;
	logic                arrived;
	logic                keep_going;
	dir_t                leave_dir;
	logic                stopping;

	function automatic floor_t step_floor(input floor_t f, input dir_t d);
		return (d == DIR_UP) ? f + floor_t'(1) : f - floor_t'(1);
	endfunction

	function automatic engine_t drive(input dir_t d);
		return (d == DIR_UP) ? ENGINE_UP : ENGINE_DOWN;
	endfunction

	// floor is the target while travelling, level_display the last one reached
	assign arrived = (state == TRAVEL) && (timer == TRAVEL_W'(TRAVEL_CYCLES - 1));
	assign keep_going = !stop_here && go && (go_dir == dir);
	assign leave_dir = go ? go_dir : dir;
	assign stopping = (arrived && !keep_going) || (state == PARKED && !go && calls_here);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= PARKED;
			timer <= '0;
			floor <= '0;
			dir <= DIR_UP;
			engine <= ENGINE_IDLE;
			level_display <= '0;
			door_request <= 1'b0;
			clear_valid <= 1'b0;
		end else begin
			door_request <= stopping;
			clear_valid <= stopping;
			case (state)
				PARKED: begin
					if (go) begin
						state <= TRAVEL;
						dir <= go_dir;
						floor <= step_floor(floor, go_dir);
						engine <= drive(go_dir);
						timer <= '0;
					end else if (calls_here) begin
						state <= DOORS; // serve a call at the parked floor
					end
				end
				TRAVEL: begin
					timer <= arrived ? '0 : timer + 1'b1;
					if (arrived) begin
						level_display <= floor;
						if (keep_going) begin
							floor <= step_floor(floor, dir);
						end else begin
							state <= DOORS;
							engine <= ENGINE_IDLE;
							dir <= leave_dir;
						end
					end
				end
				DOORS: begin
					if (!door_busy && !door_request) begin
						state <= PARKED; // wait for the whole door cycle
					end
				end
				default: state <= PARKED;
			endcase
		end
	end

	// clear payload, qualified by clear_valid
	always_ff @(posedge clk) begin
		if (stopping) begin
			clear_floor <= floor;
			clear_dir <= leave_dir;
			clear_all <= !go;
		end
	end

	a_idle_with_door: assert property (
		@(posedge clk) disable iff (!reset)
		door_busy |-> engine == ENGINE_IDLE
	) else $error("engine running during a door cycle");

	// floor only steps by one, never wrapping past either end
	a_floor_range: assert property (
		@(posedge clk) disable iff (!reset)
		(floor != $past(floor)) |->
			(dir == DIR_UP && $past(floor) != TOP_FLOOR && floor == $past(floor) + 1'b1) ||
			(dir == DIR_DOWN && $past(floor) != '0 && floor == $past(floor) - 1'b1)
	) else $error("floor left the shaft");

endmodule

// ==== logic/dispatch.sv ====
// elevator stop and direction decision
`timescale 1ns/100ps

module dispatch (
	input  elevator_pkg::floor_mask_t cabin_calls,
	input  elevator_pkg::floor_mask_t up_calls,
	input  elevator_pkg::floor_mask_t down_calls,
	input  elevator_pkg::floor_t      floor,
	input  elevator_pkg::dir_t        dir,
	output logic                      stop_here,
	output logic                      calls_here,
	output logic                      go,
	output elevator_pkg::dir_t        go_dir
);
	import elevator_pkg::*;

	floor_mask_t all_calls;
	floor_mask_t above_mask;
	floor_mask_t below_mask;
	logic        calls_above;
	logic        calls_below;
	logic        calls_ahead;
	logic        calls_behind;
	logic        hall_with;
	logic        hall_against;
	dir_t        reverse_dir;

	assign all_calls = cabin_calls | up_calls | down_calls;

	// floors strictly above and strictly below the car
	always_comb begin
		above_mask = '0;
		below_mask = '0;
		for (int i = 0; i < NUM_FLOORS; i++) begin
			above_mask[i] = (i > int'(floor));
			below_mask[i] = (i < int'(floor));
		end
	end

	assign calls_above = |(all_calls & above_mask);
	assign calls_below = |(all_calls & below_mask);

	assign calls_ahead = (dir == DIR_UP) ? calls_above : calls_below;
	assign calls_behind = (dir == DIR_UP) ? calls_below : calls_above;

	// hall calls at this floor split by travel direction
	assign hall_with = (dir == DIR_UP) ? up_calls[floor] : down_calls[floor];
	assign hall_against = (dir == DIR_UP) ? down_calls[floor] : up_calls[floor];

	assign calls_here = cabin_calls[floor] | up_calls[floor] | down_calls[floor];

	// collective rule, opposite hall call only served at the end of the sweep
	assign stop_here = cabin_calls[floor] | hall_with | (hall_against & ~calls_ahead);

	assign reverse_dir = (dir == DIR_UP) ? DIR_DOWN : DIR_UP;

	// keep direction while anything is ahead, else turn around
	assign go = calls_ahead | calls_behind;
	assign go_dir = calls_ahead ? dir : reverse_dir;

endmodule

// ==== logic/door_control.sv ====
// elevator door sequencer
`timescale 1ns/100ps

module door_control (
	input  logic                clk,
	input  logic                reset,
	input  logic                door_request,
	input  logic                open_btn,
	input  logic                close_btn,
	output elevator_pkg::door_t door,
	output logic                door_busy
);
	import elevator_pkg::*;

	logic [DWELL_W-1:0] dwell;
	logic               dwell_done;

	assign dwell_done = (dwell == DWELL_W'(DWELL_CYCLES - 1));

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			door <= DOOR_IDLE;
			door_busy <= 1'b0;
			dwell <= '0;
		end else begin
			case (door)
				DOOR_OPEN: begin
					door <= DOOR_IDLE; // open pulse lasts one cycle
					dwell <= '0;
				end
				DOOR_CLOSE: begin
					if (open_btn) begin
						door <= DOOR_OPEN; // reopen
					end else begin
						door <= DOOR_IDLE;
						door_busy <= 1'b0;
					end
				end
				default: begin
					if (!door_busy) begin
						if (door_request) begin
							door <= DOOR_OPEN;
							door_busy <= 1'b1;
						end
					end else if (open_btn) begin
						dwell <= '0; // restart the dwell
					end else if (close_btn || dwell_done) begin
						door <= DOOR_CLOSE;
					end else begin
						dwell <= dwell + 1'b1;
					end
				end
			endcase
		end
	end

	a_open_single: assert property (
		@(posedge clk) disable iff (!reset)
		door == DOOR_OPEN |=> door != DOOR_OPEN
	) else $error("door open shown on consecutive cycles");

endmodule

// ==== logic/elevator_pkg.sv ====
// elevator shared definitions
package elevator_pkg;

	localparam int NUM_FLOORS = 8;

	typedef logic [$clog2(NUM_FLOORS)-1:0] floor_t; // floor number
	typedef logic [NUM_FLOORS-1:0] floor_mask_t; // one bit per floor

	localparam floor_t TOP_FLOOR = floor_t'(NUM_FLOORS - 1);

	localparam int TRAVEL_CYCLES = 4; // cycles per floor
	localparam int DWELL_CYCLES = 8; // door held open
	localparam int TRAVEL_W = $clog2(TRAVEL_CYCLES);
	localparam int DWELL_W = $clog2(DWELL_CYCLES);

	// hall buttons that physically exist
	localparam floor_mask_t UP_BUTTONS = {1'b0, {(NUM_FLOORS - 1){1'b1}}};
	localparam floor_mask_t DOWN_BUTTONS = {{(NUM_FLOORS - 1){1'b1}}, 1'b0};

	typedef enum logic [1:0] {
		ENGINE_IDLE = 2'd0,
		ENGINE_DOWN = 2'd1,
		ENGINE_UP   = 2'd2
	} engine_t;

	typedef enum logic [1:0] {
		DOOR_IDLE  = 2'd0,
		DOOR_OPEN  = 2'd1,
		DOOR_CLOSE = 2'd2
	} door_t;

	typedef enum logic {
		DIR_DOWN = 1'b0,
		DIR_UP   = 1'b1
	} dir_t;

	typedef enum logic [1:0] {
		PARKED,
		TRAVEL,
		DOORS
	} car_state_t;

endpackage

// ==== logic/elevator_top.sv ====
// elevator controller top level
`timescale 1ns/100ps

module elevator_top (
	input  logic                      clk,
	input  logic                      reset,
	input  elevator_pkg::floor_mask_t btn_in,
	input  elevator_pkg::floor_mask_t btn_up_out,
	input  elevator_pkg::floor_mask_t btn_down_out,
	input  logic                      open_btn,
	input  logic                      close_btn,
	output elevator_pkg::engine_t     engine,
	output elevator_pkg::door_t       door,
	output elevator_pkg::floor_t      level_display
);
	import elevator_pkg::*;

	floor_mask_t cabin_calls;
	floor_mask_t up_calls;
	floor_mask_t down_calls;
	floor_t      floor;
	dir_t        dir;
	logic        stop_here;
	logic        calls_here;
	logic        go;
	dir_t        go_dir;
	logic        door_request;
	logic        door_busy;
	logic        clear_valid;
	floor_t      clear_floor;
	dir_t        clear_dir;
	logic        clear_all;

	call_register u_call_register (
		.clk          (clk),
		.reset        (reset),
		.btn_in       (btn_in),
		.btn_up_out   (btn_up_out),
		.btn_down_out (btn_down_out),
		.clear_valid  (clear_valid),
		.clear_floor  (clear_floor),
		.clear_dir    (clear_dir),
		.clear_all    (clear_all),
		.cabin_calls  (cabin_calls),
		.up_calls     (up_calls),
		.down_calls   (down_calls)
	);

	dispatch u_dispatch (
		.cabin_calls (cabin_calls),
		.up_calls    (up_calls),
		.down_calls  (down_calls),
		.floor       (floor),
		.dir         (dir),
		.stop_here   (stop_here),
		.calls_here  (calls_here),
		.go          (go),
		.go_dir      (go_dir)
	);

	car_motion u_car_motion (
		.clk           (clk),
		.reset         (reset),
		.stop_here     (stop_here),
		.calls_here    (calls_here),
		.go            (go),
		.go_dir        (go_dir),
		.door_busy     (door_busy),
		.floor         (floor),
		.dir           (dir),
		.engine        (engine),
		.level_display (level_display),
		.door_request  (door_request),
		.clear_valid   (clear_valid),
		.clear_floor   (clear_floor),
		.clear_dir     (clear_dir),
		.clear_all     (clear_all)
	);

	door_control u_door_control (
		.clk          (clk),
		.reset        (reset),
		.door_request (door_request),
		.open_btn     (open_btn),
		.close_btn    (close_btn),
		.door         (door),
		.door_busy    (door_busy)
	);

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f elevator.f --top-module elevator_tb -o elevator_sim
./obj_dir/elevator_sim > sim.log
cat sim.log
grep -q "TEST PASSED" sim.log

// ==== tests/clock_gen.sv ====
// testbench clock and reset
`timescale 1ns/100ps

module clock_gen (
	output logic clk,
	output logic reset
);
	localparam int PERIOD = 40;
	localparam int RESET_CYCLES = 16;

	initial begin
		clk = 1'b0;
		reset = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b1; // release away from the active edge
	end

	always #(PERIOD / 2) clk = ~clk;

endmodule

// ==== tests/elevator_tb.sv ====
// elevator controller testbench
`timescale 1ns/100ps

module elevator_tb;
	import elevator_pkg::*;

	localparam int RANDOM_CALLS = 40;
	localparam int NUM_TESTS = 4 + RANDOM_CALLS;
	localparam int WATCHDOG_CYCLES =
		NUM_TESTS * NUM_FLOORS * (TRAVEL_CYCLES + DWELL_CYCLES + 4) + 2000;
	localparam int IDLE_SETTLE = 12; // longer than any idle stretch inside a door cycle

	logic        clk;
	logic        reset;
	floor_mask_t btn_in;
	floor_mask_t btn_up_out;
	floor_mask_t btn_down_out;
	logic        open_btn;
	logic        close_btn;
	engine_t     engine;
	door_t       door;
	floor_t      level_display;

	floor_mask_t model_cabin;
	floor_mask_t model_up;
	floor_mask_t model_down;
	floor_t      model_floor;
	dir_t        model_dir;
	int          value_errors = 0;
	int          event_errors = 0;
	int          cycle = 0;
	logic        door_window = 1'b0;
	int          open_floors[$];

	clock_gen clock0 (.clk(clk), .reset(reset));

	elevator_top dut0 (
		.clk(clk), .reset(reset), .btn_in(btn_in), .btn_up_out(btn_up_out),
		.btn_down_out(btn_down_out), .open_btn(open_btn), .close_btn(close_btn),
		.engine(engine), .door(door), .level_display(level_display)
	);

	always @(posedge clk) cycle <= cycle + 1;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic dir_t opposite(input dir_t d);
		return (d == DIR_UP) ? DIR_DOWN : DIR_UP;
	endfunction

	// any call strictly beyond floor f in direction d
	function automatic logic calls_beyond(input floor_mask_t calls, input int f, input dir_t d);
		logic any;
		any = 1'b0;
		for (int i = 0; i < NUM_FLOORS; i++) begin
			if (calls[floor_t'(i)] && ((d == DIR_UP && i > f) || (d == DIR_DOWN && i < f))) begin
				any = 1'b1;
			end
		end
		return any;
	endfunction

	function automatic logic stop_rule(input floor_mask_t cab, input floor_mask_t up,
		input floor_mask_t dn, input int f, input dir_t d);
		logic with_dir;
		logic against;
		with_dir = (d == DIR_UP) ? up[floor_t'(f)] : dn[floor_t'(f)];
		against = (d == DIR_UP) ? dn[floor_t'(f)] : up[floor_t'(f)];
		return cab[floor_t'(f)] | with_dir | (against & !calls_beyond(cab | up | dn, f, d));
	endfunction

	// next floor whose door opens, -1 when the car stays parked
	function automatic int expected_next_stop(input floor_mask_t cab, input floor_mask_t up,
		input floor_mask_t dn, input int f, input dir_t d, output dir_t arrive_dir);
		floor_mask_t all;
		int          pos;
		dir_t        travel;
		all = cab | up | dn;
		pos = f;
		travel = d;
		arrive_dir = d;
		if (calls_beyond(all, f, d)) begin
			travel = d;
		end else if (calls_beyond(all, f, opposite(d))) begin
			travel = opposite(d);
		end else if (all[floor_t'(f)]) begin
			return f;
		end else begin
			return -1;
		end
		for (int hop = 0; hop < NUM_FLOORS; hop++) begin
			pos = (travel == DIR_UP) ? pos + 1 : pos - 1;
			if (pos < 0 || pos >= NUM_FLOORS) begin
				return -1;
			end
			if (stop_rule(cab, up, dn, pos, travel)) begin
				arrive_dir = travel;
				return pos;
			end
		end
		return -1;
	endfunction

	// clearing rule applied to the model calls
	task automatic serve_model_stop(input int f, input dir_t d);
		floor_mask_t bit_f;
		logic        ahead;
		logic        behind;
		dir_t        leave;
		ahead = calls_beyond(model_cabin | model_up | model_down, f, d);
		behind = calls_beyond(model_cabin | model_up | model_down, f, opposite(d));
		leave = ahead ? d : (behind ? opposite(d) : d);
		bit_f = floor_mask_t'(1) << f;
		model_cabin = model_cabin & ~bit_f;
		if (!(ahead || behind) || leave == DIR_UP) begin
			model_up = model_up & ~bit_f;
		end
		if (!(ahead || behind) || leave == DIR_DOWN) begin
			model_down = model_down & ~bit_f;
		end
		model_floor = floor_t'(f);
		model_dir = leave;
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		assert (expected == actual) else begin
			$display("CHECK FAILED: %s expected %0h got %0h", name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic wait_door(input door_t value, output int at_cycle);
		while (door != value) @(negedge clk);
		at_cycle = cycle;
	endtask

	task automatic wait_settled;
		int quiet;
		quiet = 0;
		while (quiet < IDLE_SETTLE) begin
			@(negedge clk);
			quiet = (engine == ENGINE_IDLE && door == DOOR_IDLE) ? quiet + 1 : 0;
		end
	endtask

	// one-cycle press, called right after a falling edge
	task automatic press_calls(input floor_mask_t cab, input floor_mask_t up,
		input floor_mask_t dn);
		btn_in = cab;
		btn_up_out = up;
		btn_down_out = dn;
		@(negedge clk);
		btn_in = '0;
		btn_up_out = '0;
		btn_down_out = '0;
	endtask

	// presses merge when latched, outputs are checked on the falling edge
	always begin : compare_stops
		int   expected;
		dir_t arrive_dir;
		@(posedge clk);
		model_cabin = model_cabin | btn_in;
		model_up = (model_up | btn_up_out) & UP_BUTTONS;
		model_down = (model_down | btn_down_out) & DOWN_BUTTONS;
		@(negedge clk);
		if (reset && door == DOOR_OPEN) begin
			door_window = 1'b1;
			expected = expected_next_stop(model_cabin, model_up, model_down,
				int'(model_floor), model_dir, arrive_dir);
			assert (expected >= 0) else begin
				$display("door opened at floor %0d with no call pending", level_display);
				event_errors++;
			end
			if (expected >= 0) begin
				check_value("level_display", expected, int'(level_display));
				serve_model_stop(expected, arrive_dir);
			end
			open_floors.push_back(int'(level_display));
		end
		if (door_window) begin
			check_value("engine", int'(ENGINE_IDLE), int'(engine));
		end
		if (door == DOOR_CLOSE) begin
			door_window = 1'b0;
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	initial begin : stimulus
		int          last;
		int          t_open;
		int          t_close;
		int          t_press;
		int          issued;
		int          quiet;
		int          f;
		int          kind;
		logic        moved;
		logic [31:0] rng_state;
		floor_mask_t cab;
		floor_mask_t up;
		floor_mask_t dn;
		btn_in = '0;
		btn_up_out = '0;
		btn_down_out = '0;
		open_btn = 1'b0;
		close_btn = 1'b0;
		model_cabin = '0;
		model_up = '0;
		model_down = '0;
		model_floor = '0;
		model_dir = DIR_UP;
		rng_state = 32'd81;
		while (!reset) @(negedge clk);

		// reset state, nothing moves without calls
		repeat (20) begin
			@(negedge clk);
			check_value("engine", int'(ENGINE_IDLE), int'(engine));
			check_value("door", int'(DOOR_IDLE), int'(door));
			check_value("level_display", 0, int'(level_display));
		end

		// single cabin call to floor 5
		press_calls(floor_mask_t'(1) << 5, '0, '0);
		while (engine == ENGINE_IDLE) @(negedge clk);
		check_value("engine", int'(ENGINE_UP), int'(engine));
		last = cycle;
		for (int lvl = 1; lvl <= 5; lvl++) begin
			while (int'(level_display) != lvl) @(negedge clk);
			check_value("level_display step cycles", TRAVEL_CYCLES, cycle - last);
			last = cycle;
		end
		check_value("engine", int'(ENGINE_IDLE), int'(engine)); // idle on arrival
		wait_door(DOOR_OPEN, t_open);
		wait_door(DOOR_CLOSE, t_close);
		check_value("door close delay", DWELL_CYCLES + 1, t_close - t_open);
		wait_settled();

		// back to 0, then a sweep of three calls
		press_calls(floor_mask_t'(1), '0, '0);
		wait_door(DOOR_OPEN, t_open);
		wait_settled();
		open_floors.delete();
		press_calls(floor_mask_t'(1) << 6, floor_mask_t'(1) << 2, floor_mask_t'(1) << 3);
		while (open_floors.size() < 3) @(negedge clk);
		check_value("sweep stop 1", 2, open_floors[0]);
		check_value("sweep stop 2", 6, open_floors[1]);
		check_value("sweep stop 3", 3, open_floors[2]);
		wait_settled();

		// call at the parked floor, then open_btn in the dwell
		press_calls(floor_mask_t'(1) << level_display, '0, '0);
		moved = 1'b0;
		while (door != DOOR_OPEN) begin
			@(negedge clk);
			moved = moved | (engine != ENGINE_IDLE);
		end
		assert (!moved) else begin
			$display("engine ran for a call at the parked floor");
			event_errors++;
		end
		repeat (3) @(negedge clk);
		t_press = cycle;
		open_btn = 1'b1;
		@(negedge clk);
		open_btn = 1'b0;
		wait_door(DOOR_CLOSE, t_close);
		check_value("door close after open_btn", t_press + DWELL_CYCLES + 1, t_close);
		wait_settled();

		// close_btn cuts the dwell short
		press_calls(floor_mask_t'(1) << level_display, '0, '0);
		wait_door(DOOR_OPEN, t_open);
		repeat (3) @(negedge clk);
		t_press = cycle;
		close_btn = 1'b1;
		@(negedge clk);
		close_btn = 0;
		wait_door(DOOR_CLOSE, t_close);
		check_value("door close after close_btn", t_press + 1, t_close);
		wait_settled();

		// random traffic, pressed while the door is open or the car is idle
		issued = 0;
		quiet = 0;
		while (issued < RANDOM_CALLS) begin
			@(negedge clk);
			quiet = (engine == ENGINE_IDLE && door == DOOR_IDLE) ? quiet + 1 : 0;
			if (door == DOOR_OPEN || quiet >= IDLE_SETTLE) begin
				rng_state = xorshift(rng_state);
				f = int'(rng_state[2:0]);
				kind = int'(rng_state[9:8]) % 3;
				if ((kind == 1 && f == NUM_FLOORS - 1) || (kind == 2 && f == 0)) begin
					kind = 0; // no such hall button
				end
				cab = (kind == 0) ? floor_mask_t'(1) << f : '0;
				up = (kind == 1) ? floor_mask_t'(1) << f : '0;
				dn = (kind == 2) ? floor_mask_t'(1) << f : '0;
				press_calls(cab, up, dn);
				quiet = 0;
				issued++;
			end
		end
		wait_settled();
		assert ((model_cabin | model_up | model_down) == '0) else begin
			$display("calls still pending after the traffic drained");
			event_errors++;
		end

		$display("errors: %0d value mismatches, %0d other failures", value_errors, event_errors);
		if (value_errors == 0 && event_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
